//--- src/dcache_cfg_pkg.sv
package dcache_cfg_pkg;

    // geometry for a 4-way, 16-set, 4-word-line cache
    localparam int WAYS       = 4;
    localparam int WAY_W      = 2;
    localparam int SETS       = 16;
    localparam int INDEX_W    = 4;
    localparam int WORDS      = 4;  // words per line
    localparam int WORD_SEL_W = 2;
    localparam int OFFSET_W   = 4;  // byte offset in a line
    localparam int TAG_W      = 24;

    typedef logic [WAY_W-1:0]      way_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [WAYS-2:0]       plru_t;  // tree bits of one set

endpackage

//--- src/dcache_bus_pkg.sv
package dcache_bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        RESPOND
    } ctrl_state_e;

    // line commands from controller to burst engine
    typedef enum logic [1:0] {
        XFER_NONE,
        XFER_READ_LINE,
        XFER_WRITE_LINE
    } xfer_cmd_e;

endpackage

//--- src/line_xfer_if.sv
`timescale 1ns/1ps

interface line_xfer_if;

    dcache_bus_pkg::xfer_cmd_e             cmd;
    logic                                  cmd_valid;
    logic [dcache_bus_pkg::ADDR_W-1:0]     line_addr;  // line aligned
    logic [dcache_bus_pkg::DATA_W-1:0]     wb_word;    // victim word at beat_idx
    logic                                  cmd_ready;
    logic                                  beat_valid; // refill word arrived
    dcache_cfg_pkg::word_sel_t             beat_idx;
    logic [dcache_bus_pkg::DATA_W-1:0]     beat_data;
    logic                                  done;       // one-cycle pulse at burst end

    modport ctrl (
        output cmd, cmd_valid, line_addr, wb_word,
        input  cmd_ready, beat_valid, beat_idx, beat_data, done
    );

    modport engine (
        input  cmd, cmd_valid, line_addr, wb_word,
        output cmd_ready, beat_valid, beat_idx, beat_data, done
    );

endinterface

//--- src/tag_store.sv
`timescale 1ns/1ps

module tag_store (
    input  logic                     clk,
    input  logic                     rst,
    input  dcache_cfg_pkg::index_t   index,
    input  dcache_cfg_pkg::tag_t     tag,
    input  logic                     touch,
    input  dcache_cfg_pkg::way_t     touch_way,
    input  logic                     fill,
    input  dcache_cfg_pkg::way_t     fill_way,
    input  logic                     set_dirty,
    input  dcache_cfg_pkg::way_t     dirty_way,
    input  logic                     dirty_val,
    output logic                     hit,
    output dcache_cfg_pkg::way_t     hit_way,
    output dcache_cfg_pkg::way_t     victim_way,
    output logic                     victim_dirty,
    output dcache_cfg_pkg::tag_t     victim_tag
);

    dcache_cfg_pkg::tag_t              tags  [dcache_cfg_pkg::WAYS][dcache_cfg_pkg::SETS];
    logic [dcache_cfg_pkg::SETS-1:0]   valid [dcache_cfg_pkg::WAYS];
    logic [dcache_cfg_pkg::SETS-1:0]   dirty [dcache_cfg_pkg::WAYS];
    dcache_cfg_pkg::plru_t             plru  [dcache_cfg_pkg::SETS];
    logic [dcache_cfg_pkg::WAYS-1:0]   match;
    dcache_cfg_pkg::plru_t             cur_tree;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < dcache_cfg_pkg::WAYS; w++) begin
            match[w] = valid[w][index] && (tags[w][index] == tag);
            if (match[w]) begin
                hit_way = dcache_cfg_pkg::way_t'(w);
            end
        end
    end

    assign hit          = |match;
    assign cur_tree     = plru[index];
    // bit0 picks the half, bit2 or bit1 the way inside it
    assign victim_way   = {cur_tree[0], cur_tree[0] ? cur_tree[2] : cur_tree[1]};
    assign victim_dirty = valid[victim_way][index] && dirty[victim_way][index];
    assign victim_tag   = tags[victim_way][index];

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[fill_way][index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < dcache_cfg_pkg::WAYS; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
            for (int s = 0; s < dcache_cfg_pkg::SETS; s++) begin
                plru[s] <= '0;
            end
        end else begin
            if (fill) begin
                valid[fill_way][index] <= 1'b1;
            end
            if (set_dirty) begin
                dirty[dirty_way][index] <= dirty_val;
            end
            if (touch) begin
                plru[index][0] <= ~touch_way[1];  // point away from the touched half
                if (touch_way[1]) begin
                    plru[index][2] <= ~touch_way[0];
                end else begin
                    plru[index][1] <= ~touch_way[0];
                end
            end
        end
    end

    // duplicate tags in one set would make the hit way ambiguous
    a_single_match: assert property (@(posedge clk) disable iff (rst) $onehot0(match));

endmodule

//--- src/data_store.sv
`timescale 1ns/1ps

module data_store (
    input  logic                                 clk,
    input  dcache_cfg_pkg::index_t               index,
    input  dcache_cfg_pkg::word_sel_t            rd_word,
    input  dcache_cfg_pkg::way_t                 hit_way,
    input  dcache_cfg_pkg::way_t                 wb_way,
    input  dcache_cfg_pkg::word_sel_t            wb_word,
    input  logic                                 wr_en,
    input  dcache_cfg_pkg::way_t                 wr_way,
    input  dcache_cfg_pkg::word_sel_t            wr_word,
    input  logic [dcache_bus_pkg::STRB_W-1:0]    wr_strb,
    input  logic [dcache_bus_pkg::DATA_W-1:0]    wr_data,
    output logic [dcache_bus_pkg::DATA_W-1:0]    rd_data,
    output logic [dcache_bus_pkg::DATA_W-1:0]    wb_data
);

    logic [dcache_bus_pkg::DATA_W-1:0] mem [dcache_cfg_pkg::WAYS][dcache_cfg_pkg::SETS]
                                           [dcache_cfg_pkg::WORDS];

    assign rd_data = mem[hit_way][index][rd_word];  // word for the core
    assign wb_data = mem[wb_way][index][wb_word];   // word for the write burst

    // byte lanes under strobe
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < dcache_bus_pkg::STRB_W; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_way][index][wr_word][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- src/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 req_valid,
    input  logic                                 req_write,
    input  logic [dcache_bus_pkg::ADDR_W-1:0]    req_addr,
    input  logic [dcache_bus_pkg::STRB_W-1:0]    req_wstrb,
    input  logic [dcache_bus_pkg::DATA_W-1:0]    req_wdata,
    input  logic                                 hit,
    input  dcache_cfg_pkg::way_t                 hit_way,
    input  dcache_cfg_pkg::way_t                 victim_way,
    input  logic                                 victim_dirty,
    input  dcache_cfg_pkg::tag_t                 victim_tag,
    input  logic [dcache_bus_pkg::DATA_W-1:0]    rd_data,
    input  logic [dcache_bus_pkg::DATA_W-1:0]    wb_data,
    output logic                                 busy,
    output logic                                 resp_valid,
    output logic [dcache_bus_pkg::DATA_W-1:0]    resp_rdata,
    output dcache_cfg_pkg::index_t               index,
    output dcache_cfg_pkg::tag_t                 tag,
    output logic                                 touch,
    output dcache_cfg_pkg::way_t                 touch_way,
    output logic                                 fill,
    output dcache_cfg_pkg::way_t                 fill_way,
    output logic                                 set_dirty,
    output dcache_cfg_pkg::way_t                 dirty_way,
    output logic                                 dirty_val,
    output dcache_cfg_pkg::word_sel_t            rd_word,
    output dcache_cfg_pkg::way_t                 wb_way,
    output dcache_cfg_pkg::word_sel_t            wb_word,
    output logic                                 wr_en,
    output dcache_cfg_pkg::way_t                 wr_way,
    output dcache_cfg_pkg::word_sel_t            wr_word,
    output logic [dcache_bus_pkg::STRB_W-1:0]    wr_strb,
    output logic [dcache_bus_pkg::DATA_W-1:0]    wr_data,
    line_xfer_if.ctrl                            xfer
);

    dcache_bus_pkg::ctrl_state_e           state;
    logic [dcache_bus_pkg::ADDR_W-1:0]     addr_r;
    logic                                  write_r;
    logic [dcache_bus_pkg::STRB_W-1:0]     wstrb_r;
    logic [dcache_bus_pkg::DATA_W-1:0]     wdata_r;
    dcache_cfg_pkg::way_t                  vic_way_r;
    dcache_cfg_pkg::tag_t                  vic_tag_r;
    logic                                  cmd_sent;   // command taken, waiting for done
    logic                                  lookup_hit;
    logic                                  refill_beat;
    logic [dcache_bus_pkg::DATA_W-1:0]     strb_mask;

    assign index   = addr_r[dcache_cfg_pkg::OFFSET_W +: dcache_cfg_pkg::INDEX_W];
    assign tag     = addr_r[dcache_bus_pkg::ADDR_W-1 -: dcache_cfg_pkg::TAG_W];
    assign rd_word = addr_r[dcache_cfg_pkg::OFFSET_W-1:2];

    assign busy       = (state != dcache_bus_pkg::IDLE);
    assign resp_valid = (state == dcache_bus_pkg::RESPOND);
    assign resp_rdata = (resp_valid && !write_r) ? rd_data : '0;  // stores just ack

    assign lookup_hit  = (state == dcache_bus_pkg::LOOKUP) && hit;
    assign refill_beat = (state == dcache_bus_pkg::REFILL) && xfer.beat_valid;

    // tree, valid and dirty updates
    assign fill      = (state == dcache_bus_pkg::REFILL) && xfer.done;
    assign fill_way  = vic_way_r;
    assign touch     = lookup_hit || fill;
    assign touch_way = lookup_hit ? hit_way : vic_way_r;
    assign set_dirty = (lookup_hit && write_r) || fill;
    assign dirty_way = touch_way;
    assign dirty_val = write_r;  // load refill leaves the line clean

    always_comb begin
        for (int b = 0; b < dcache_bus_pkg::STRB_W; b++) begin
            strb_mask[8*b +: 8] = {8{wstrb_r[b]}};
        end
    end

    // store hit writes one word, refill writes every beat
    assign wr_en   = (lookup_hit && write_r) || refill_beat;
    assign wr_way  = lookup_hit ? hit_way : vic_way_r;
    assign wr_word = lookup_hit ? rd_word : xfer.beat_idx;
    assign wr_strb = lookup_hit ? wstrb_r : '1;
    always_comb begin
        wr_data = xfer.beat_data;
        if (lookup_hit) begin
            wr_data = wdata_r;
        end else if (write_r && xfer.beat_idx == rd_word) begin
            wr_data = (xfer.beat_data & ~strb_mask) | (wdata_r & strb_mask);  // merge store
        end
    end

    assign wb_way       = vic_way_r;
    assign wb_word      = xfer.beat_idx;
    assign xfer.wb_word = wb_data;

    assign xfer.cmd_valid = !cmd_sent && (state == dcache_bus_pkg::WRITEBACK ||
                                          state == dcache_bus_pkg::REFILL);
    assign xfer.cmd       = (state == dcache_bus_pkg::WRITEBACK) ? dcache_bus_pkg::XFER_WRITE_LINE
                          : (state == dcache_bus_pkg::REFILL)    ? dcache_bus_pkg::XFER_READ_LINE
                          : dcache_bus_pkg::XFER_NONE;
    assign xfer.line_addr = (state == dcache_bus_pkg::WRITEBACK)
                          ? {vic_tag_r, index, {dcache_cfg_pkg::OFFSET_W{1'b0}}}
                          : {tag, index, {dcache_cfg_pkg::OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (state == dcache_bus_pkg::IDLE && req_valid) begin
            addr_r  <= req_addr;
            write_r <= req_write;
            wstrb_r <= req_wstrb;
            wdata_r <= req_wdata;
        end
        if (state == dcache_bus_pkg::LOOKUP) begin
            vic_way_r <= victim_way;  // tree stays put until refill done
            vic_tag_r <= victim_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= dcache_bus_pkg::IDLE;
            cmd_sent <= 1'b0;
        end else begin
            if (xfer.done) begin
                cmd_sent <= 1'b0;
            end else if (xfer.cmd_valid && xfer.cmd_ready) begin
                cmd_sent <= 1'b1;
            end
            case (state)
                dcache_bus_pkg::IDLE: begin
                    if (req_valid) state <= dcache_bus_pkg::LOOKUP;
                end
                dcache_bus_pkg::LOOKUP: begin
                    if (hit) state <= dcache_bus_pkg::RESPOND;
                    else if (victim_dirty) state <= dcache_bus_pkg::WRITEBACK;
                    else state <= dcache_bus_pkg::REFILL;
                end
                dcache_bus_pkg::WRITEBACK: begin
                    if (xfer.done) state <= dcache_bus_pkg::REFILL;
                end
                dcache_bus_pkg::REFILL: begin
                    if (xfer.done) state <= dcache_bus_pkg::RESPOND;
                end
                default: state <= dcache_bus_pkg::IDLE;  // RESPOND
            endcase
        end
    end

    // the engine holds a command only while a miss is in progress
    a_cmd_in_miss: assert property (@(posedge clk) disable iff (rst)
        !xfer.cmd_ready |->
        (state == dcache_bus_pkg::WRITEBACK || state == dcache_bus_pkg::REFILL));

endmodule

//--- src/burst_master.sv
`timescale 1ns/1ps

module burst_master (
    input  logic                                 clk,
    input  logic                                 rst,
    output logic [dcache_bus_pkg::ADDR_W-1:0]    ar_addr,
    output logic                                 ar_valid,
    input  logic                                 ar_ready,
    input  logic [dcache_bus_pkg::DATA_W-1:0]    r_data,
    input  logic                                 r_last,
    input  logic                                 r_valid,
    output logic                                 r_ready,
    output logic [dcache_bus_pkg::ADDR_W-1:0]    aw_addr,
    output logic                                 aw_valid,
    input  logic                                 aw_ready,
    output logic [dcache_bus_pkg::DATA_W-1:0]    w_data,
    output logic                                 w_last,
    output logic                                 w_valid,
    input  logic                                 w_ready,
    input  logic                                 b_valid,
    output logic                                 b_ready,
    line_xfer_if.engine                          xfer
);

    dcache_bus_pkg::xfer_cmd_e             cur;       // command in progress
    logic [dcache_bus_pkg::ADDR_W-1:0]     addr_r;
    logic                                  addr_sent; // ar or aw taken
    logic                                  w_done;    // last w beat taken
    dcache_cfg_pkg::word_sel_t             cnt;
    logic                                  rd_act;
    logic                                  wr_act;
    logic                                  r_beat;
    logic                                  w_beat;

    assign rd_act = (cur == dcache_bus_pkg::XFER_READ_LINE);
    assign wr_act = (cur == dcache_bus_pkg::XFER_WRITE_LINE);

    assign xfer.cmd_ready = (cur == dcache_bus_pkg::XFER_NONE);

    assign ar_addr  = addr_r;
    assign ar_valid = rd_act && !addr_sent;
    assign r_ready  = rd_act && addr_sent;
    assign r_beat   = r_valid && r_ready;

    assign aw_addr  = addr_r;
    assign aw_valid = wr_act && !addr_sent;
    assign w_valid  = wr_act && addr_sent && !w_done;  // data after address
    assign w_data   = xfer.wb_word;
    assign w_last   = (cnt == dcache_cfg_pkg::word_sel_t'(dcache_cfg_pkg::WORDS - 1));
    assign w_beat   = w_valid && w_ready;
    assign b_ready  = wr_act && w_done;

    assign xfer.beat_valid = r_beat;
    assign xfer.beat_idx   = cnt;  // also selects the write-back word
    assign xfer.beat_data  = r_data;
    assign xfer.done       = (r_beat && r_last) || (b_valid && b_ready);

    always_ff @(posedge clk) begin
        if (xfer.cmd_valid && xfer.cmd_ready) begin
            addr_r <= xfer.line_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cur       <= dcache_bus_pkg::XFER_NONE;
            addr_sent <= 1'b0;
            w_done    <= 1'b0;
            cnt       <= '0;
        end else if (xfer.done) begin
            cur       <= dcache_bus_pkg::XFER_NONE;
            addr_sent <= 1'b0;
            w_done    <= 1'b0;
            cnt       <= '0;
        end else begin
            if (xfer.cmd_valid && xfer.cmd_ready) begin
                cur <= xfer.cmd;
            end
            if ((ar_valid && ar_ready) || (aw_valid && aw_ready)) begin
                addr_sent <= 1'b1;
            end
            if (r_beat || w_beat) begin
                cnt <= cnt + 1'b1;
            end
            if (w_beat && w_last) begin
                w_done <= 1'b1;
            end
        end
    end

    // memory must close each read burst on the line's last word
    a_rlast_pos: assert property (@(posedge clk) disable iff (rst)
        r_beat |-> (r_last == (cnt == dcache_cfg_pkg::word_sel_t'(dcache_cfg_pkg::WORDS - 1))));

endmodule

//--- src/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 req_valid,
    input  logic                                 req_write,
    input  logic [dcache_bus_pkg::ADDR_W-1:0]    req_addr,
    input  logic [dcache_bus_pkg::STRB_W-1:0]    req_wstrb,
    input  logic [dcache_bus_pkg::DATA_W-1:0]    req_wdata,
    output logic                                 busy,
    output logic                                 resp_valid,
    output logic [dcache_bus_pkg::DATA_W-1:0]    resp_rdata,
    output logic [dcache_bus_pkg::ADDR_W-1:0]    ar_addr,
    output logic                                 ar_valid,
    input  logic                                 ar_ready,
    input  logic [dcache_bus_pkg::DATA_W-1:0]    r_data,
    input  logic                                 r_last,
    input  logic                                 r_valid,
    output logic                                 r_ready,
    output logic [dcache_bus_pkg::ADDR_W-1:0]    aw_addr,
    output logic                                 aw_valid,
    input  logic                                 aw_ready,
    output logic [dcache_bus_pkg::DATA_W-1:0]    w_data,
    output logic                                 w_last,
    output logic                                 w_valid,
    input  logic                                 w_ready,
    input  logic                                 b_valid,
    output logic                                 b_ready
);

    dcache_cfg_pkg::index_t              index;
    dcache_cfg_pkg::tag_t                tag, victim_tag;
    dcache_cfg_pkg::way_t                hit_way, victim_way, touch_way, fill_way, dirty_way;
    dcache_cfg_pkg::way_t                wb_way, wr_way;
    dcache_cfg_pkg::word_sel_t           rd_word, wb_word, wr_word;
    logic                                hit, victim_dirty, touch, fill, set_dirty, dirty_val;
    logic                                wr_en;
    logic [dcache_bus_pkg::STRB_W-1:0]   wr_strb;
    logic [dcache_bus_pkg::DATA_W-1:0]   wr_data, rd_data, wb_data;

    line_xfer_if xfer ();

    tag_store u_tag_store (
        .clk, .rst, .index, .tag, .touch, .touch_way, .fill, .fill_way,
        .set_dirty, .dirty_way, .dirty_val,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
    );

    data_store u_data_store (
        .clk, .index, .rd_word, .hit_way, .wb_way, .wb_word,
        .wr_en, .wr_way, .wr_word, .wr_strb, .wr_data, .rd_data, .wb_data
    );

    cache_ctrl u_cache_ctrl (
        .clk, .rst, .req_valid, .req_write, .req_addr, .req_wstrb, .req_wdata,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag, .rd_data, .wb_data,
        .busy, .resp_valid, .resp_rdata,
        .index, .tag, .touch, .touch_way, .fill, .fill_way,
        .set_dirty, .dirty_way, .dirty_val,
        .rd_word, .wb_way, .wb_word, .wr_en, .wr_way, .wr_word, .wr_strb, .wr_data,
        .xfer (xfer.ctrl)
    );

    burst_master u_burst_master (
        .clk, .rst,
        .ar_addr, .ar_valid, .ar_ready,
        .r_data, .r_last, .r_valid, .r_ready,
        .aw_addr, .aw_valid, .aw_ready,
        .w_data, .w_last, .w_valid, .w_ready,
        .b_valid, .b_ready,
        .xfer (xfer.engine)
    );

endmodule

//--- testbench/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
    parameter logic [31:0] PATTERN = 32'h0,
    parameter int          SEED    = 1
) (
    input  logic        clk,
    input  logic        rst,
    input  int          stall_pct,  // chance in percent that a channel holds off
    input  logic [31:0] ar_addr,
    input  logic        ar_valid,
    output logic        ar_ready,
    output logic [31:0] r_data,
    output logic        r_last,
    output logic        r_valid,
    input  logic        r_ready,
    input  logic [31:0] aw_addr,
    input  logic        aw_valid,
    output logic        aw_ready,
    input  logic [31:0] w_data,
    input  logic        w_last,
    input  logic        w_valid,
    output logic        w_ready,
    output logic        b_valid,
    input  logic        b_ready
);

    logic [31:0] store [logic [31:0]];  // written words only, the rest follow the pattern
    logic [31:0] ar_log [$];
    logic [31:0] aw_log [$];            // line base of every write-back
    logic [31:0] rd_base;
    logic [31:0] wr_base;
    logic [1:0]  rd_cnt;
    logic [1:0]  wr_cnt;
    logic        rd_act;
    logic        b_pend;

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (store.exists(addr)) begin
            return store[addr];
        end
        return addr ^ PATTERN;
    endfunction

    function automatic logic go();
        return ($urandom % 100) >= stall_pct;
    endfunction

    initial begin
        void'($urandom(SEED));
        ar_ready = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        r_valid  = 1'b0;
        r_data   = 32'h0;
        r_last   = 1'b0;
        b_valid  = 1'b0;
        rd_act   = 1'b0;
        b_pend   = 1'b0;
        rd_cnt   = 2'd0;
        wr_cnt   = 2'd0;
        forever begin
            @(posedge clk);
            if (rst) begin
                ar_ready <= 1'b0;
                aw_ready <= 1'b0;
                w_ready  <= 1'b0;
                r_valid  <= 1'b0;
                b_valid  <= 1'b0;
                rd_act   <= 1'b0;
                b_pend   <= 1'b0;
            end else begin
                ar_ready <= go();
                aw_ready <= go();
                w_ready  <= go();
                if (ar_valid && ar_ready) begin
                    rd_base <= ar_addr;
                    rd_cnt  <= 2'd0;
                    rd_act  <= 1'b1;
                    ar_log.push_back(ar_addr);
                end
                // one beat at a time, held until taken
                if (r_valid && r_ready) begin
                    r_valid <= 1'b0;
                    if (r_last) begin
                        rd_act <= 1'b0;
                    end
                end else if (rd_act && !r_valid && go()) begin
                    r_valid <= 1'b1;
                    r_data  <= read_word(rd_base + {28'd0, rd_cnt, 2'b00});
                    r_last  <= (rd_cnt == 2'd3);
                    rd_cnt  <= rd_cnt + 2'd1;
                end
                if (aw_valid && aw_ready) begin
                    wr_base <= aw_addr;
                    wr_cnt  <= 2'd0;
                    aw_log.push_back(aw_addr);
                end
                if (w_valid && w_ready) begin
                    store[wr_base + {28'd0, wr_cnt, 2'b00}] = w_data;
                    wr_cnt <= wr_cnt + 2'd1;
                    if (w_last) begin
                        b_pend <= 1'b1;  // response owed
                    end
                end
                if (b_valid && b_ready) begin
                    b_valid <= 1'b0;
                end else if (b_pend && !b_valid && go()) begin
                    b_valid <= 1'b1;
                    b_pend  <= 1'b0;
                end
            end
        end
    end

endmodule

//--- testbench/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    localparam int          SEED    = 34;
    localparam logic [31:0] PATTERN = 32'h5ac3_96e1;  // memory word = address ^ this
    localparam int          TIMEOUT = 2000;           // cycles per wait

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_write;
    logic [31:0] req_addr;
    logic [3:0]  req_wstrb;
    logic [31:0] req_wdata;
    logic        busy;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic [31:0] ar_addr;
    logic        ar_valid;
    logic        ar_ready;
    logic [31:0] r_data;
    logic        r_last;
    logic        r_valid;
    logic        r_ready;
    logic [31:0] aw_addr;
    logic        aw_valid;
    logic        aw_ready;
    logic [31:0] w_data;
    logic        w_last;
    logic        w_valid;
    logic        w_ready;
    logic        b_valid;
    logic        b_ready;
    int          stall_pct;
    int          checks;
    int          errors;

    dcache_top uut (.*);

    mem_model #(.PATTERN(PATTERN), .SEED(SEED)) memory (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] mem_pattern(input logic [31:0] addr);
        return addr ^ PATTERN;
    endfunction

    // byte b of the result comes from nw when strb[b] is set
    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = nw[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic flag_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic send_req(input logic wr, input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] wdata);
        int n;
        n = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= addr;
        req_wstrb <= strb;
        req_wdata <= wdata;
        @(negedge clk);
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            flag_failure("busy never dropped, request could not be issued");
        end
        @(posedge clk);  // accepting edge
        req_valid <= 1'b0;
    endtask

    // lat counts cycles from the accepting edge
    task automatic wait_resp(output logic [31:0] rdata, output int lat);
        logic seen;
        seen = 1'b0;
        lat  = 0;
        while (!seen && lat < TIMEOUT) begin
            @(negedge clk);
            lat++;
            seen = resp_valid;
            compare("busy", {31'd0, busy}, 32'd1);  // high from acceptance through response
        end
        rdata = resp_rdata;
        if (!seen) begin
            flag_failure("no response from the cache within the timeout");
        end
    endtask

    task automatic access(input logic wr, input logic [31:0] addr, input logic [3:0] strb,
                          input logic [31:0] wdata, output logic [31:0] rdata, output int lat);
        send_req(wr, addr, strb, wdata);
        wait_resp(rdata, lat);
    endtask

    task automatic load_expect(input logic [31:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        int          lat;
        access(1'b0, addr, 4'h0, 32'h0, data, lat);
        compare("resp_rdata", data, exp);
    endtask

    task automatic expect_one_burst(input string name, input logic [31:0] log[$],
                                    input logic [31:0] base);
        compare({name, " count"}, log.size(), 32'd1);
        if (log.size() > 0) begin
            compare(name, log[0], base);
        end
    endtask

    task automatic reset_state();
        @(negedge clk);
        compare("busy", {31'd0, busy}, 32'd0);
        compare("resp_valid", {31'd0, resp_valid}, 32'd0);
        compare("ar_valid", {31'd0, ar_valid}, 32'd0);
        compare("aw_valid", {31'd0, aw_valid}, 32'd0);
        compare("w_valid", {31'd0, w_valid}, 32'd0);
        compare("r_ready", {31'd0, r_ready}, 32'd0);
        compare("b_ready", {31'd0, b_ready}, 32'd0);
        load_expect(32'h0000_1044, mem_pattern(32'h0000_1044));
    endtask

    task automatic hit_timing();
        logic [31:0] data;
        int          lat;
        access(1'b0, 32'h0000_104c, 4'h0, 32'h0, data, lat);  // same line as the reset load
        compare("resp_rdata", data, mem_pattern(32'h0000_104c));
        compare("hit latency", lat, 32'd2);
    endtask

    task automatic byte_strobes(input logic [31:0] base);
        logic [31:0] data;
        int          lat;
        load_expect(base, mem_pattern(base));
        access(1'b1, base + 32'h8, 4'b0110, 32'h1122_3344, data, lat);  // store hit
        compare("resp_rdata", data, 32'h0);
        compare("store hit latency", lat, 32'd2);
        load_expect(base + 32'h8, merge_bytes(mem_pattern(base + 32'h8), 32'h1122_3344, 4'b0110));
        access(1'b1, base + 32'h14, 4'b1001, 32'hdead_beef, data, lat);  // merged into refill
        compare("resp_rdata", data, 32'h0);
        load_expect(base + 32'h14, merge_bytes(mem_pattern(base + 32'h14), 32'hdead_beef,
                                               4'b1001));
        load_expect(base + 32'h10, mem_pattern(base + 32'h10));
    endtask

    // lines k go to one set, fills land in ways 0, 2, 1, 3
    task automatic replacement_order(input logic [31:0] base);
        logic [31:0] line;
        logic [31:0] data;
        int          lat;
        for (int k = 0; k < 5; k++) begin
            line = base + 32'h1000 * k;
            memory.ar_log.delete();
            load_expect(line, mem_pattern(line));
            expect_one_burst("ar_addr", memory.ar_log, line);
        end
        memory.ar_log.delete();
        load_expect(base, mem_pattern(base));  // line 0 was the victim of line 4
        expect_one_burst("ar_addr", memory.ar_log, base);
        for (int k = 2; k < 5; k++) begin
            line = base + 32'h1000 * k;
            access(1'b0, line, 4'h0, 32'h0, data, lat);
            compare("resp_rdata", data, mem_pattern(line));
            compare("hit latency", lat, 32'd2);
        end
    endtask

    task automatic dirty_writeback(input logic [31:0] base);
        logic [31:0] data;
        logic [31:0] stored;
        int          lat;
        stored = ~mem_pattern(base + 32'h8);
        access(1'b1, base + 32'h8, 4'hf, stored, data, lat);
        compare("resp_rdata", data, 32'h0);
        memory.aw_log.delete();
        for (int k = 1; k < 5; k++) begin
            load_expect(base + 32'h1000 * k, mem_pattern(base + 32'h1000 * k));
        end
        expect_one_burst("aw_addr", memory.aw_log, base);  // only the dirty line goes out
        load_expect(base + 32'h8, stored);
        load_expect(base + 32'h4, mem_pattern(base + 32'h4));
    endtask

    initial begin
        checks    = 0;
        errors    = 0;
        stall_pct = 0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = 32'h0;
        req_wstrb = 4'h0;
        req_wdata = 32'h0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        reset_state();
        hit_timing();
        byte_strobes(32'h0002_0020);
        replacement_order(32'h0003_0060);
        dirty_writeback(32'h0004_0070);

        // same checks with heavy stalls on every channel
        @(posedge clk);
        stall_pct <= 75;
        byte_strobes(32'h0005_0080);
        replacement_order(32'h0006_00a0);
        dirty_writeback(32'h0007_00b0);

        finish_run();
    end

endmodule

//--- sim.f
src/dcache_cfg_pkg.sv
src/dcache_bus_pkg.sv
src/line_xfer_if.sv
src/tag_store.sv
src/data_store.sv
src/cache_ctrl.sv
src/burst_master.sv
src/dcache_top.sv
testbench/mem_model.sv
testbench/tb_dcache.sv

//--- run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_dcache -f sim.f
./obj_dir/Vtb_dcache > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
